/* hdl/apb_operand_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "magnitude_params.svh"

module apb_operand_port
    import magnitude_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output logic          push,          // One strobe per completed DATA write
    output operand_pair_t push_data,
    input  wire [3:0]     count,         // FIFO occupancy
    input  wire           busy           // Engine not idle
);

    logic        access;                 // Access phase of a transfer
    logic        data_hit;
    logic        status_hit;
    logic        legal;                  // Address and direction accepted
    logic        full;
    logic        stall;                  // Wait state request
    logic [31:0] status_word;

    assign access     = apb_req.psel && apb_req.penable;
    assign data_hit   = apb_req.paddr == `MAG_APB_AW'(`MAG_ADDR_DATA);
    assign status_hit = apb_req.paddr == `MAG_APB_AW'(`MAG_ADDR_STATUS);

    // DATA takes writes and STATUS only reads
    assign legal = data_hit || (status_hit && !apb_req.pwrite);

    assign full = count == 4'(`MAG_FIFO_DEPTH);  // Port derives full itself

    // Back-pressure to the host until the engine drains a slot
    assign stall = apb_req.psel && apb_req.pwrite && data_hit && full;

    // Count in [3:0] with full at bit 4 and busy at bit 8
    assign status_word = {23'd0, busy, 3'd0, full, count};

    assign push = access && apb_req.pwrite && data_hit && !full;  // Same edge as completion

    assign push_data = '{
        x: apb_req.pwdata[`MAG_OP_W-1:0],              // x from low byte
        y: apb_req.pwdata[2*`MAG_OP_W-1:`MAG_OP_W]     // y from next byte
    };

    assign apb_rsp.pready  = !stall;
    assign apb_rsp.pslverr = access && !legal;  // No state change on error
    assign apb_rsp.prdata  = (access && status_hit && !apb_req.pwrite) ?
                             status_word : 32'd0;  // Reads of DATA return zero

    // A pushed pair shows up in the FIFO count on the next cycle
    a_push_counted: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |=> count != 4'd0
    ) else $error("push not reflected in count");

    // Host holds a stalled write until the FIFO has room
    a_stall_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (access && stall) |=> apb_req.psel && apb_req.penable && apb_req.pwrite
    ) else $error("stalled write abandoned");

endmodule

`default_nettype wire

/* hdl/magnitude_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "magnitude_params.svh"

module magnitude_engine
    import magnitude_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                not_empty,
    input  wire operand_pair_t head,
    output logic               pop,        // Takes the FIFO head
    output logic               busy,
    output logic               res_valid,
    output mag_result_t        res,
    input  wire                res_ready
);

    typedef enum logic [2:0] {ST_IDLE, ST_SQUARE, ST_SUM, ST_ROOT, ST_HOLD} state_t;

    state_t                   state;
    logic [2*`MAG_OP_W-1:0]   sq_x;        // x squared
    logic [2*`MAG_OP_W-1:0]   sq_y;        // y squared
    logic [`MAG_SUM_W-1:0]    sum;
    logic [`MAG_ROOT_W-1:0]   root;        // Bits resolved so far
    logic [`MAG_SUM_W-1:0]    root_sq;     // root * root tracked alongside
    logic [`MAG_ROOT_W-1:0]   mask;        // One-hot bit under trial
    logic                     exact;
    logic [`MAG_ROOT_W-1:0]   cand;
    logic [`MAG_SUM_W:0]      cand_sq;     // One extra bit since 511^2 overflows 17
    logic                     keep;

    assign cand    = root | mask;
    assign cand_sq = (`MAG_SUM_W+1)'(cand) * (`MAG_SUM_W+1)'(cand);
    assign keep    = cand_sq <= {1'b0, sum};  // Bit stays if not past the sum

    assign pop       = (state == ST_IDLE) && not_empty;
    assign busy      = state != ST_IDLE;
    assign res_valid = state == ST_HOLD;
    assign res       = '{root: root, exact: exact};

    // FSM walks from idle to square to sum to root to hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            mask  <= '0;
        end else begin
            case (state)
                ST_IDLE:   if (pop) state <= ST_SQUARE;
                ST_SQUARE: state <= ST_SUM;          // Sum formed on this edge
                ST_SUM: begin
                    state <= ST_ROOT;
                    mask  <= {1'b1, {(`MAG_ROOT_W-1){1'b0}}};  // Start at bit 8
                end
                ST_ROOT: begin
                    mask <= mask >> 1;
                    if (mask[0]) state <= ST_HOLD;   // Bit 0 done
                end
                ST_HOLD:   if (res_ready) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: if (pop) begin
                sq_x <= head.x * head.x;             // Squares load on the pop edge
                sq_y <= head.y * head.y;
            end
            ST_SQUARE: sum <= `MAG_SUM_W'(sq_x) + `MAG_SUM_W'(sq_y);
            ST_SUM: begin
                root    <= '0;                       // Seed the search
                root_sq <= '0;
            end
            ST_ROOT: begin
                if (keep) begin
                    root    <= cand;
                    root_sq <= cand_sq[`MAG_SUM_W-1:0];
                end
                // Last trial decides exact
                if (mask[0]) exact <= (keep ? cand_sq : {1'b0, root_sq}) == {1'b0, sum};
            end
            default: ;                               // Hold keeps res steady
        endcase
    end

    // Result held until the sink takes it
    a_res_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res))
    ) else $error("res changed while stalled");

    // res_valid rises 11 cycles after the pop edge
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(res_valid) |-> $past(pop, 12)
    ) else $error("result latency off");

endmodule

`default_nettype wire

/* hdl/magnitude_params.svh */
`ifndef MAGNITUDE_PARAMS_SVH
`define MAGNITUDE_PARAMS_SVH

// Operand and result widths
`define MAG_OP_W        8       // One unsigned coordinate
`define MAG_ROOT_W      9       // Max magnitude 360 needs 9 bits
`define MAG_SUM_W       17      // 2 * 255^2 = 130050

// Queue
`define MAG_FIFO_DEPTH  4       // Power of two, count port holds up to 8

// APB register map, byte addresses
`define MAG_APB_AW      4
`define MAG_ADDR_DATA   'h0     // Write only, pushes a pair
`define MAG_ADDR_STATUS 'h4     // Read only

`endif

/* hdl/magnitude_pkg.sv */
`default_nettype none

package magnitude_pkg;

`include "magnitude_params.svh"

    typedef struct packed {
        logic [`MAG_OP_W-1:0] x;         // First coordinate
        logic [`MAG_OP_W-1:0] y;         // Second coordinate
    } operand_pair_t;                    // One FIFO entry

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`MAG_APB_AW-1:0] paddr;   // Byte address
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;             // Low while a DATA write waits
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`MAG_ROOT_W-1:0] root;    // Floor of the square root
        logic                   exact;   // Root squared equals the sum
    } mag_result_t;

endpackage

`default_nettype wire

/* hdl/magnitude_top.sv */
`timescale 1ns/1ps
`default_nettype none

module magnitude_top
    import magnitude_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output logic          res_valid,
    output mag_result_t   res,
    input  wire           res_ready
);

    logic          push;                   // Port to FIFO
    operand_pair_t push_data;
    logic [3:0]    count;                  // FIFO occupancy back to port
    logic          pop;                    // Engine takes head
    operand_pair_t head;
    logic          not_empty;
    logic          busy;                   // Engine state for status word

    apb_operand_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .push      (push),
        .push_data (push_data),
        .count     (count),
        .busy      (busy)
    );

    operand_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .count     (count)
    );

    magnitude_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

/* hdl/operand_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "magnitude_params.svh"

module operand_fifo
    import magnitude_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                push,
    input  wire operand_pair_t push_data,
    input  wire                pop,
    output operand_pair_t      head,       // Oldest entry
    output logic               not_empty,
    output logic [3:0]         count       // Occupancy 0..DEPTH
);

    localparam int DEPTH = `MAG_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    operand_pair_t mem [DEPTH];            // Entry storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    // Storage write, no reset on payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 4'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    assign head      = mem[rd_ptr];        // Visible one cycle after push
    assign not_empty = count != 4'd0;

    // Engine only pops what is there
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> not_empty
    ) else $error("pop from empty FIFO");

    // Port stalls the host instead of overrunning
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> count != 4'(DEPTH)
    ) else $error("push into full FIFO");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector magnitude testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module magnitude_tb -o magnitude_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/magnitude_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> FAIL$' "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

if ! grep -q '^>>> PASS$' "$LOG"; then
    echo "Testbench did not report a result"
    exit 1
fi

echo "Simulation passed"
exit 0

/* src.f */
+incdir+hdl
hdl/magnitude_pkg.sv
hdl/apb_operand_port.sv
hdl/operand_fifo.sv
hdl/magnitude_engine.sv
hdl/magnitude_top.sv
testbench/magnitude_tb.sv

/* testbench/magnitude_input.txt */
# All fields hex. W x y root exact | R addr expected | E addr (expect pslverr)
# S cycles (hold the sink) | D (wait for all results and compare)
R 4 0
W 0 0 0 1
W 3 4 5 1
W ff ff 168 0
W 1 1 1 0
W 5 c d 1
W 8 f 11 1
W a a e 0
W ff 0 ff 1
D
S 40
W 64 c8 df 0
W 14 15 1d 1
W 7 18 19 1
W 2 3 3 0
W 9 28 29 1
R 4 114
W 80 80 b5 0
W 21 38 41 1
D
E 4
E 8
R 0 0
W 0 1 1 1
W 6 8 a 1
D
R 4 0

/* testbench/magnitude_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module magnitude_tb
    import magnitude_pkg::*;
();

    localparam int    HALF_PERIOD     = 10;      // 20 ns clock
    localparam int    CYCLES_PER_LINE = 200;     // Watchdog budget per file line
    localparam int    QUIET_CYCLES    = 16;      // Window for stray extra results
    localparam int    QUEUE_SLOTS     = 5;       // Four FIFO entries plus the pair in the engine
    localparam string INPUT_FILE      = "testbench/magnitude_input.txt";

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        res_valid;
    mag_result_t res;
    logic        res_ready;

    int          errors;
    int          checks;
    int          stall_left;                    // Sink held off while nonzero
    int          line_total;                    // Sizes the watchdog
    logic        sink_on;
    mag_result_t expected_q[$];                 // Results in write order
    mag_result_t got_q[$];                      // Results as the sink took them

    magnitude_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One APB transfer through setup and access phases until pready
    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int waits);
        @(negedge clk);
        apb_req.psel    = 1'b1;                 // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;                 // Access phase
        waits = 0;
        #1;                                     // Let pready settle
        while (!apb_rsp.pready) begin
            @(negedge clk);
            #1;
            waits = waits + 1;
        end
        rdata = apb_rsp.prdata;                 // Taken before the completing edge
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic compare_results();
        int n;
        n = expected_q.size();
        checks = checks + 1;
        if (got_q.size() != n) begin
            errors = errors + 1;
            $display("Result count wrong: got %0d results, expected %0d", got_q.size(), n);
        end
        for (int i = 0; i < n && i < got_q.size(); i++) begin
            check_value("res.root", 32'(got_q[i].root), 32'(expected_q[i].root));
            check_value("res.exact", 32'(got_q[i].exact), 32'(expected_q[i].exact));
        end
        expected_q.delete();
        got_q.delete();
    endtask

    // Sink picks res_ready for the next rising edge and logs the handshake due there
    initial begin : sink
        wait (sink_on);
        forever begin
            @(negedge clk);
            if (stall_left > 0) begin
                res_ready  = 1'b0;              // Forced stall
                stall_left = stall_left - 1;
            end else begin
                res_ready = ($urandom % 3) != 0;
            end
            if (res_valid && res_ready) got_q.push_back(res);
        end
    end

    initial begin : watchdog
        wait (line_total > 0);
        repeat (line_total * CYCLES_PER_LINE) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles",
                 line_total * CYCLES_PER_LINE);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int          fd;
        int          f0;
        int          f1;
        int          f2;
        int          f3;
        int          waits;
        int          n;
        string       line;
        byte         cmd;
        logic [31:0] rd_data;
        logic        rd_err;
        logic        must_wait;
        mag_result_t exp_res;

        void'($urandom(12213));                 // Single seed for the sink pattern
        clk        = 1'b0;
        rst_n      = 1'b0;
        apb_req    = '0;
        res_ready  = 1'b0;
        errors     = 0;
        checks     = 0;
        stall_left = 0;
        line_total = 0;
        sink_on    = 1'b0;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value("res_valid", 32'(res_valid), 32'd0);  // Idle out of reset
        sink_on = 1'b1;

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("Could not open the stimulus file %s", INPUT_FILE);
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) line_total = line_total + 1;
            end
            $fclose(fd);
            fd = $fopen(INPUT_FILE, "r");       // Second pass runs the commands
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() < 1) continue;
                cmd = line.getc(0);
                if (cmd == "#" || cmd == "\n") continue;  // Comments and blanks
                f0 = 0;
                f1 = 0;
                f2 = 0;
                f3 = 0;
                n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
                case (cmd)
                    "W": begin
                        // Sink held and every slot taken means this write must wait
                        must_wait = stall_left > 0 &&
                                    expected_q.size() - got_q.size() >= QUEUE_SLOTS;
                        apb_transfer(1'b1, 4'h0, {16'd0, f1[7:0], f0[7:0]},
                                     rd_data, rd_err, waits);
                        check_value("pslverr", 32'(rd_err), 32'd0);
                        if (must_wait) begin
                            checks = checks + 1;
                            if (waits == 0) begin
                                errors = errors + 1;
                                $display("A DATA write into a full FIFO completed without a wait state");
                            end
                        end
                        if (waits > 0 && stall_left > 0) begin
                            errors = errors + 1;
                            $display("A stalled DATA write completed while the sink was held");
                        end
                        exp_res.root  = f2[8:0];
                        exp_res.exact = f3[0];
                        expected_q.push_back(exp_res);
                    end
                    "R": begin
                        apb_transfer(1'b0, f0[3:0], 32'd0, rd_data, rd_err, waits);
                        check_value("prdata", rd_data, f1);
                        check_value("pslverr", 32'(rd_err), 32'd0);
                    end
                    "E": begin
                        // Payload would show up as an extra result if pushed
                        apb_transfer(1'b1, f0[3:0], 32'h0303, rd_data, rd_err, waits);
                        check_value("pslverr", 32'(rd_err), 32'd1);
                    end
                    "S": stall_left = f0;
                    "D": begin
                        while (got_q.size() < expected_q.size()) @(negedge clk);
                        repeat (QUIET_CYCLES) @(negedge clk);
                        compare_results();
                    end
                    default: begin
                        errors = errors + 1;
                        $display("Unknown command in stimulus file: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
